// File: include/ifetch_defines.svh
`ifndef IFETCH_DEFINES_SVH
`define IFETCH_DEFINES_SVH

// first fetch address out of reset
`define IFETCH_RESET_PC 32'h8000_0000

// instruction sram window, starts where the core boots
`define IMEM_BASE `IFETCH_RESET_PC
`define IMEM_WORDS 1024 // depth in 32-bit words
`define IMEM_AW 10 // word index width, log2 of depth

// cycles from ar handshake to rvalid
`define SRAM_LATENCY 4

// axi response codes
`define RESP_OKAY 2'b00
`define RESP_SLVERR 2'b10

`endif

// File: src/ifetch_pkg.sv
`default_nettype none

`include "ifetch_defines.svh"

package ifetch_pkg;

    typedef logic [31:0] addr_t; // byte address
    typedef logic [31:0] word_t; // one instruction
    typedef logic [1:0] resp_t; // axi resp field
    typedef logic [`IMEM_AW-1:0] imem_idx_t; // word index into the array

    // read address channel payload
    typedef struct packed {
        addr_t addr;
    } ar_req_t;

    // read data channel payload
    typedef struct packed {
        word_t data;
        resp_t resp;
    } r_rsp_t;

    // what the decoder gets per instruction
    typedef struct packed {
        addr_t pc;
        word_t inst;
        logic  fault; // resp was not okay
    } fetch_out_t;

    typedef enum logic [1:0] {
        F_IDLE, // nothing in flight
        F_ISSUE, // ar being presented
        F_WAIT, // waiting for r, delivers on handshake
        F_DROP // r is stale, swallow it
    } fetch_state_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACCESS, // latency countdown
        S_RESP // r held until rready
    } slave_state_t;

endpackage

`default_nettype wire

// File: src/imem_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_defines.svh"

// single port style word store
// load port used by the testbench before run goes high
// read port driven by the sram slave
module imem_array (
    input  wire logic                  clk,
    input  wire logic                  load_en,
    input  wire ifetch_pkg::imem_idx_t load_idx,
    input  wire ifetch_pkg::word_t     load_data,
    input  wire logic                  rd_en,
    input  wire ifetch_pkg::imem_idx_t rd_idx,
    output ifetch_pkg::word_t          rd_data
);
    import ifetch_pkg::*;

    word_t mem [`IMEM_WORDS]; // instruction storage, no reset

    // load write, one word per cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end
    end

    // registered read
    // holds last word until the next strobe so the slave
    // can pick it up whenever its countdown ends
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx]; // old data on same-index load
        end
    end

endmodule

`default_nettype wire

// File: src/sram_read_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_defines.svh"

// axi-lite read-only slave in front of imem_array
// one transaction at a time, fixed latency
module sram_read_slave (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  arvalid,
    output logic                       arready,
    input  wire ifetch_pkg::ar_req_t   ar,
    output logic                       rvalid,
    input  wire logic                  rready,
    output ifetch_pkg::r_rsp_t         r,
    output logic                       mem_rd_en,
    output ifetch_pkg::imem_idx_t      mem_rd_idx,
    input  wire ifetch_pkg::word_t     mem_rd_data
);
    import ifetch_pkg::*;

    localparam int CNT_W = $clog2(`SRAM_LATENCY + 1); // fits the load value

    slave_state_t     state;
    logic [CNT_W-1:0] cnt; // cycles left in S_ACCESS
    addr_t            addr_q; // accepted address
    logic             ar_hs;
    logic             r_hs;
    logic             rsp_load; // last access cycle

    // inside the sram window and word aligned
    function automatic logic in_window(addr_t a);
        addr_t off;
        off = a - `IMEM_BASE; // wraps for addresses below base
        return (off < addr_t'(`IMEM_WORDS * 4)) && (a[1:0] == 2'b00);
    endfunction

    // byte address to array word index
    function automatic imem_idx_t word_idx(addr_t a);
        addr_t off;
        off = a - `IMEM_BASE;
        return off[`IMEM_AW+1:2];
    endfunction

    assign arready = (state == S_IDLE); // only idle accepts
    assign rvalid  = (state == S_RESP);
    assign ar_hs   = arvalid && arready;
    assign r_hs    = rvalid && rready;

    // strobe the array on the accepting edge, good addresses only
    assign mem_rd_en  = ar_hs && in_window(ar.addr);
    assign mem_rd_idx = word_idx(ar.addr);

    assign rsp_load = (state == S_ACCESS) && (cnt == CNT_W'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (ar_hs) begin
                        state <= S_ACCESS;
                        cnt   <= CNT_W'(`SRAM_LATENCY); // rvalid lands latency edges later
                    end
                end
                S_ACCESS: begin
                    cnt <= cnt - 1'b1;
                    if (rsp_load) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (r_hs) begin
                        state <= S_IDLE; // arready back up after this edge
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // address and response payload
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q <= ar.addr;
        end
        if (rsp_load) begin
            if (in_window(addr_q)) begin
                r <= '{data: mem_rd_data, resp: `RESP_OKAY};
            end else begin
                r <= '{data: '0, resp: `RESP_SLVERR}; // out of window or misaligned
            end
        end
    end

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_defines.svh"

// pc keeper and axi-lite read master
// exactly one request in flight, decoder can stall and redirect
module fetch_unit (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  run,
    input  wire logic                  redirect,
    input  wire ifetch_pkg::addr_t     redirect_pc,
    output logic                       arvalid,
    input  wire logic                  arready,
    output ifetch_pkg::ar_req_t        ar,
    input  wire logic                  rvalid,
    output logic                       rready,
    input  wire ifetch_pkg::r_rsp_t    r,
    input  wire logic                  inst_ready,
    output logic                       inst_valid,
    output ifetch_pkg::fetch_out_t     fetch
);
    import ifetch_pkg::*;

    fetch_state_t state;
    addr_t        pc;
    logic         stale; // redirect arrived while ar was held
    logic         ar_hs;
    logic         r_hs;
    logic         ar_load; // first cycle in F_ISSUE
    logic         deliver; // good response taken in F_WAIT

    assign ar_hs   = arvalid && arready;
    assign r_hs    = rvalid && rready;
    assign ar_load = (state == F_ISSUE) && !arvalid;
    assign deliver = (state == F_WAIT) && r_hs && !redirect; // redirect wins

    // decoder back-pressure only matters for live responses
    always_comb begin
        case (state)
            F_WAIT:  rready = inst_ready;
            F_DROP:  rready = 1'b1; // discard as fast as it comes
            default: rready = 1'b0;
        endcase
    end

    // pc, redirect first, then sequential advance
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `IFETCH_RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (deliver) begin
            pc <= pc + 32'd4; // slverr also moves on
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= F_IDLE;
            arvalid    <= 1'b0;
            stale      <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= deliver; // one-cycle pulse
            case (state)
                F_IDLE: begin
                    if (run) begin
                        state <= F_ISSUE;
                    end
                end
                F_ISSUE: begin
                    if (ar_load) begin
                        arvalid <= 1'b1; // raised the edge after entry
                    end else if (ar_hs) begin
                        arvalid <= 1'b0;
                        stale   <= 1'b0;
                        state   <= (stale || redirect) ? F_DROP : F_WAIT;
                    end else if (redirect) begin
                        stale <= 1'b1; // ar must stay stable, drop the answer later
                    end
                end
                F_WAIT: begin
                    if (r_hs) begin
                        state <= F_IDLE; // taken, delivered or discarded
                    end else if (redirect) begin
                        state <= F_DROP;
                    end
                end
                F_DROP: begin
                    if (r_hs) begin
                        state <= F_IDLE;
                    end
                end
                default: begin
                    state <= F_IDLE;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (ar_load) begin
            ar.addr <= redirect ? redirect_pc : pc; // same-cycle redirect goes straight out
        end
        if (deliver) begin
            fetch <= '{pc: pc, inst: r.data, fault: (r.resp != `RESP_OKAY)};
        end
    end

endmodule

`default_nettype wire

// File: src/ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

// fetch unit -> axi-lite read -> sram slave -> array
module ifetch_top (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  run,
    input  wire logic                  load_en,
    input  wire ifetch_pkg::imem_idx_t load_idx,
    input  wire ifetch_pkg::word_t     load_data,
    input  wire logic                  redirect,
    input  wire ifetch_pkg::addr_t     redirect_pc,
    input  wire logic                  inst_ready,
    output logic                       inst_valid,
    output ifetch_pkg::fetch_out_t     fetch
);
    import ifetch_pkg::*;

    // read address channel
    logic      arvalid;
    logic      arready;
    ar_req_t   ar;
    // read data channel
    logic      rvalid;
    logic      rready;
    r_rsp_t    r;
    // slave to array
    logic      mem_rd_en;
    imem_idx_t mem_rd_idx;
    word_t     mem_rd_data;

    fetch_unit fetch_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .arvalid     (arvalid),
        .arready     (arready),
        .ar          (ar),
        .rvalid      (rvalid),
        .rready      (rready),
        .r           (r),
        .inst_ready  (inst_ready),
        .inst_valid  (inst_valid),
        .fetch       (fetch)
    );

    sram_read_slave sram_read_slave_inst (
        .clk         (clk),
        .rst         (rst),
        .arvalid     (arvalid),
        .arready     (arready),
        .ar          (ar),
        .rvalid      (rvalid),
        .rready      (rready),
        .r           (r),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_idx  (mem_rd_idx),
        .mem_rd_data (mem_rd_data)
    );

    // load port straight from the top
    imem_array imem_array_inst (
        .clk       (clk),
        .load_en   (load_en),
        .load_idx  (load_idx),
        .load_data (load_data),
        .rd_en     (mem_rd_en),
        .rd_idx    (mem_rd_idx),
        .rd_data   (mem_rd_data)
    );

endmodule

`default_nettype wire

// File: tb/ifetch_props.sv
`timescale 1ns/1ps
`default_nettype none

// axi-lite read handshake rules plus the decoder side pulse rule
// bound twice, once per end of the read channel
module ifetch_props (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                arvalid,
    input wire logic                arready,
    input wire ifetch_pkg::ar_req_t ar,
    input wire logic                rvalid,
    input wire logic                rready,
    input wire ifetch_pkg::r_rsp_t  r,
    input wire logic                inst_valid // tied low on the slave side
);

    int   n_fail = 0; // failed assertions so far, watched by the testbench
    logic pending; // address accepted, response not yet taken

    // outstanding request tracker, set on ar, cleared on r
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (arvalid && arready) begin
            pending <= 1'b1;
        end else if (rvalid && rready) begin
            pending <= 1'b0;
        end
    end

    // ar held until accepted
    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            $error("ar dropped or changed before arready");
            n_fail++;
        end

    // r held until taken
    a_r_stable: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(r))
        else begin
            $error("r dropped or changed before rready");
            n_fail++;
        end

    a_busy_pending: assert property (@(posedge clk) disable iff (rst)
        pending |-> !arready) // no new address until the answer is taken
        else begin
            $error("arready high with a response pending");
            n_fail++;
        end

    a_inst_pulse: assert property (@(posedge clk) disable iff (rst)
        inst_valid |=> !inst_valid)
        else begin
            $error("inst_valid high on two cycles in a row");
            n_fail++;
        end

endmodule

bind fetch_unit ifetch_props fetch_props_inst (
    .clk(clk), .rst(rst), .arvalid(arvalid), .arready(arready), .ar(ar),
    .rvalid(rvalid), .rready(rready), .r(r), .inst_valid(inst_valid)
);

bind sram_read_slave ifetch_props slave_props_inst (
    .clk(clk), .rst(rst), .arvalid(arvalid), .arready(arready), .ar(ar),
    .rvalid(rvalid), .rready(rready), .r(r), .inst_valid(1'b0)
);

`default_nettype wire

// File: tb/ifetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_defines.svh"

module ifetch_tb;
    import ifetch_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_FETCH = 400; // deliveries before the run ends
    localparam int BP_BOUND = 8; // longest inst_ready low stretch
    localparam int REDIRECT_ODDS = 32; // roughly one redirect per this many cycles
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + `IMEM_WORDS + 16
                                   + NUM_FETCH * (`SRAM_LATENCY + BP_BOUND + 4);

    logic       clk;
    logic       rst;
    logic       run;
    logic       load_en;
    imem_idx_t  load_idx;
    word_t      load_data;
    logic       redirect;
    addr_t      redirect_pc;
    logic       inst_ready;
    logic       inst_valid;
    fetch_out_t fetch;

    word_t  model_mem [`IMEM_WORDS]; // mirror of what went through the load port
    addr_t  model_pc; // pc the next delivery must carry
    int     n_delivered;
    int     n_fault;
    int     n_redirect;
    int     ready_low; // current inst_ready low stretch
    integer seed;

    ifetch_top ifetch_top_inst (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .load_en     (load_en),
        .load_idx    (load_idx),
        .load_data   (load_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst_ready  (inst_ready),
        .inst_valid  (inst_valid),
        .fetch       (fetch)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error: %s expected %h actual %h at %0t", name, exp, act, $time);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // sram window, word aligned only
    function automatic logic pc_in_window(addr_t a);
        return (a >= `IMEM_BASE) && (a < `IMEM_BASE + addr_t'(`IMEM_WORDS * 4))
            && (a[1:0] == 2'b00);
    endfunction

    function automatic word_t model_inst(addr_t a);
        addr_t off;
        off = a - `IMEM_BASE;
        return pc_in_window(a) ? model_mem[off >> 2] : '0; // bad address reads zero
    endfunction

    // mostly legal targets, some past the top, below base or misaligned
    function automatic addr_t pick_target();
        int kind;
        int slot;
        kind = $unsigned($random(seed)) % 8;
        slot = $unsigned($random(seed)) % `IMEM_WORDS;
        case (kind)
            0, 1, 2, 3: return `IMEM_BASE + addr_t'(slot * 4);
            4: return `IMEM_BASE + addr_t'((`IMEM_WORDS - 1 - slot % 4) * 4); // runs off the end
            5: return `IMEM_BASE + addr_t'(`IMEM_WORDS * 4 + (slot % 64) * 4);
            6: return `IMEM_BASE - addr_t'((slot % 64 + 1) * 4);
            default: return `IMEM_BASE + addr_t'(slot * 4 + 1 + slot % 3);
        endcase
    endfunction

    // decoder side, one call per rising edge
    task automatic drive_decoder();
        logic rdy;
        rdy = ($unsigned($random(seed)) % 10) >= 3; // ready about 70 percent
        if (ready_low >= BP_BOUND) rdy = 1'b1;
        ready_low = rdy ? 0 : ready_low + 1;
        inst_ready <= rdy;
        // first delivery must come from the reset pc
        if (!redirect && n_delivered > 0 && ($unsigned($random(seed)) % REDIRECT_ODDS) == 0) begin
            redirect    <= 1'b1;
            redirect_pc <= pick_target();
        end else begin
            redirect <= 1'b0; // single-cycle pulse
        end
    endtask

    // monitor at the falling edge, all dut outputs settled
    always @(negedge clk) begin
        if (!rst) begin
            check("assertions", 32'd0, ifetch_top_inst.fetch_unit_inst.fetch_props_inst.n_fail);
            check("assertions", 32'd0,
                  ifetch_top_inst.sram_read_slave_inst.slave_props_inst.n_fail);
            if (!run) check("idle_no_fetch", 32'd0, inst_valid);
            if (inst_valid) begin
                if (n_delivered == 0) check("first_pc", `IFETCH_RESET_PC, fetch.pc);
                check("fetch_pc", model_pc, fetch.pc); // order and no old-path leftovers
                if (pc_in_window(model_pc)) begin
                    check("fetch_inst", model_inst(model_pc), fetch.inst);
                    check("fetch_fault", 32'd0, fetch.fault);
                end else begin
                    check("fault_inst", 32'd0, fetch.inst);
                    check("fault_flag", 32'd1, fetch.fault);
                    n_fault++;
                end
                model_pc = model_pc + 32'd4; // faults advance too
                n_delivered++;
            end
            // seen here, taken by the dut on the coming edge
            if (redirect) begin
                model_pc = redirect_pc;
                n_redirect++;
            end
        end
    end

    initial begin
        word_t w;
        seed        = 32'hd81d;
        rst         = 1'b1;
        run         = 1'b0;
        load_en     = 1'b0;
        load_idx    = '0;
        load_data   = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        inst_ready  = 1'b0;
        model_pc    = `IFETCH_RESET_PC;
        n_delivered = 0;
        n_fault     = 0;
        n_redirect  = 0;
        ready_low   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        // fill every word, run held low
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            @(posedge clk);
            w = $random(seed);
            load_en   <= 1'b1;
            load_idx  <= imem_idx_t'(i);
            load_data <= w;
            model_mem[i] = w;
        end
        @(posedge clk);
        load_en <= 1'b0;
        repeat (4) @(posedge clk); // quiet gap before run
        run <= 1'b1;
        while (n_delivered < NUM_FETCH) begin
            @(posedge clk);
            drive_decoder();
        end
        if (n_fault == 0 || n_redirect == 0) begin
            $display("fault or redirect path never exercised: %0d faults, %0d redirects",
                     n_fault, n_redirect);
            $display("test failed");
            $fatal(1);
        end else begin
            $display("test passed");
            $finish;
        end
    end

    // watchdog, sized from the fetch count
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("fetch stalled: %0d of %0d instructions delivered before the timeout",
                 n_delivered, NUM_FETCH);
        $display("test failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
src/ifetch_pkg.sv
src/imem_array.sv
src/sram_read_slave.sv
src/fetch_unit.sv
src/ifetch_top.sv
tb/ifetch_props.sv
tb/ifetch_tb.sv
